// File: flist.f
+incdir+include
source/tcp_pkg.sv
source/tcp_seg_if.sv
source/rx_seg_classifier.sv
source/tcp_conn_engine.sv
source/tx_hdr_fifo.sv
source/tx_req_ack_port.sv
source/tcp_server_top.sv
verification/tcp_server_tb.sv

// File: verification/tcp_server_tb.sv
`default_nettype none

`include "tcp_macros.svh"

module tcp_server_tb;
    import tcp_pkg::*;

    localparam int    NROWS     = 9;
    localparam int    TIMEOUT   = 200;
    localparam port_t LOC_PORT  = 16'd5001;
    localparam port_t CLI_PORT  = 16'd40000;
    localparam port_t CLI_PORT2 = 16'd40001;
    localparam ipv4_t CLI_IP    = 32'hc0a8_0117;
    localparam seq_t  ISN       = `TCP_ISN;
    localparam seq_t  CSEQ      = 32'h1000_0000;
    localparam seq_t  CSEQ2     = 32'h7000_0400;
    localparam len_t  LEN_D     = 16'd100;
    localparam len_t  LEN_A     = 16'd64;
    localparam len_t  LEN_B     = 16'd32;

    // one table row, either an rx header or one or two send requests
    typedef struct packed {
        logic       is_send;
        port_t      src_port;
        port_t      dst_port;
        seq_t       seq;
        seq_t       ack;
        flags_t     flags;
        len_t       len;      // rx payload, or first send
        len_t       len_b;    // second send, zero for none
        logic [1:0] n_hdr;
        logic       conn;     // connected after the step
    } step_t;

    typedef struct packed {
        flags_t flags;
        seq_t   seq;
        seq_t   ack;
        len_t   len;
    } hdr_t;

    logic   clk;
    logic   tcp_rst;
    port_t  loc_port;
    logic   listen;
    logic   connected;
    logic   rx_hdr_v;
    ipv4_t  rx_src_ip;
    port_t  rx_src_port;
    port_t  rx_dst_port;
    seq_t   rx_seq;
    seq_t   rx_ack;
    flags_t rx_flags;
    len_t   rx_len;
    logic   send_v;
    len_t   send_len;
    logic   send_rdy;
    logic   tx_req;
    logic   tx_ack;
    ipv4_t  tx_dst_ip;
    port_t  tx_dst_port;
    seq_t   tx_seq;
    seq_t   tx_ack_num;
    flags_t tx_flags;
    len_t   tx_len;

    step_t  steps     [NROWS];
    hdr_t   exp_hdr   [NROWS][2];
    string  step_name [NROWS];
    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     cur_step;
    logic   timed_out;

    tcp_server_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic build_table();
        seq_t rcv_ack;
        seq_t snd_seq;
        rcv_ack = CSEQ + 32'd1 + LEN_D;       // local ack after the data segment
        snd_seq = ISN + 32'd1 + LEN_A + LEN_B; // local seq after both sends
        // is_send, src_port, dst_port, seq, ack, flags, len, len_b, n_hdr, conn
        steps[0] = {1'b0, CLI_PORT, LOC_PORT + 16'd1, CSEQ, 32'd0, `TCP_FLAG_SYN,
                    16'd0, 16'd0, 2'd0, 1'b0};
        steps[1] = {1'b0, CLI_PORT, LOC_PORT, CSEQ, 32'd0, `TCP_FLAG_SYN,
                    16'd0, 16'd0, 2'd1, 1'b0};
        steps[2] = {1'b0, CLI_PORT, LOC_PORT, CSEQ + 32'd1, ISN + 32'd1, `TCP_FLAG_ACK,
                    16'd0, 16'd0, 2'd0, 1'b1};
        steps[3] = {1'b0, CLI_PORT, LOC_PORT, CSEQ + 32'd1, ISN + 32'd1, `TCP_FLAG_ACK,
                    LEN_D, 16'd0, 2'd1, 1'b1};
        steps[4] = {1'b0, CLI_PORT, LOC_PORT, CSEQ + 32'd1, ISN + 32'd1, `TCP_FLAG_ACK,
                    16'd20, 16'd0, 2'd0, 1'b1};  // stale seq, already acked
        steps[5] = {1'b1, CLI_PORT, LOC_PORT, 32'd0, 32'd0, 9'h000,
                    LEN_A, LEN_B, 2'd2, 1'b1};
        steps[6] = {1'b0, CLI_PORT, LOC_PORT, rcv_ack, snd_seq,
                    `TCP_FLAG_FIN | `TCP_FLAG_ACK, 16'd0, 16'd0, 2'd2, 1'b1};
        steps[7] = {1'b0, CLI_PORT, LOC_PORT, rcv_ack + 32'd1, snd_seq + 32'd1,
                    `TCP_FLAG_ACK, 16'd0, 16'd0, 2'd0, 1'b0};
        steps[8] = {1'b0, CLI_PORT2, LOC_PORT, CSEQ2, 32'd0, `TCP_FLAG_SYN,
                    16'd0, 16'd0, 2'd1, 1'b0};

        exp_hdr[1][0] = {`TCP_FLAG_SYNACK, ISN, CSEQ + 32'd1, 16'd0};
        exp_hdr[3][0] = {`TCP_FLAG_ACK, ISN + 32'd1, rcv_ack, 16'd0};
        exp_hdr[5][0] = {`TCP_FLAG_PSHACK, ISN + 32'd1, rcv_ack, LEN_A};
        exp_hdr[5][1] = {`TCP_FLAG_PSHACK, ISN + 32'd1 + LEN_A, rcv_ack, LEN_B};
        exp_hdr[6][0] = {`TCP_FLAG_ACK, snd_seq, rcv_ack + 32'd1, 16'd0};
        exp_hdr[6][1] = {`TCP_FLAG_FINACK, snd_seq, rcv_ack + 32'd1, 16'd0};
        exp_hdr[8][0] = {`TCP_FLAG_SYNACK, ISN, CSEQ2 + 32'd1, 16'd0};

        step_name = '{"syn to foreign port", "syn", "handshake ack", "in-order data",
                      "out-of-order data", "two sends", "fin", "last ack", "syn again"};
    endtask

    task automatic check_seq(input string what, input seq_t got, input seq_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ip(input string what, input ipv4_t got, input ipv4_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_port(input string what, input port_t got, input port_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input string what, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input string what, input len_t got, input len_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("timeout in test %0d: %s for %0d cycles", cur_step, what, TIMEOUT);
    endtask

    task automatic apply_rx(input step_t s);
        rx_src_ip   = CLI_IP;
        rx_src_port = s.src_port;
        rx_dst_port = s.dst_port;
        rx_seq      = s.seq;
        rx_ack      = s.ack;
        rx_flags    = s.flags;
        rx_len      = s.len;
        rx_hdr_v    = 1'b1;
        next_cycle();
        rx_hdr_v    = 1'b0;
    endtask

    task automatic send_request(input len_t len, output logic ok);
        int n;
        n = 0;
        while (!send_rdy && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        ok = send_rdy;
        if (!ok) begin
            report_timeout("send_rdy stayed low");
        end else begin
            send_v   = 1'b1;
            send_len = len;
            next_cycle();
            send_v   = 1'b0;
        end
    endtask

    // acts as the tx_ack side of the four-phase handshake
    task automatic collect_header(output hdr_t h, output ipv4_t ip, output port_t port,
                                  output logic ok);
        int n;
        int delay;
        n = 0;
        while (!tx_req && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        ok = tx_req;
        if (!ok) begin
            report_timeout("tx_req did not rise");
        end else begin
            h     = {tx_flags, tx_seq, tx_ack_num, tx_len};
            ip    = tx_dst_ip;
            port  = tx_dst_port;
            delay = $unsigned($random(seed)) % 4; // slow ack, headers pile up in the FIFO
            repeat (delay) next_cycle();
            tx_ack = 1'b1;
            n = 0;
            while (tx_req && n < TIMEOUT) begin
                next_cycle();
                n++;
            end
            if (tx_req) begin
                ok = 1'b0;
                report_timeout("tx_req did not fall after tx_ack");
            end
            tx_ack = 1'b0;
            next_cycle();
        end
    endtask

    task automatic expect_quiet(input int i);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            next_cycle();
            if (tx_req) seen = 1'b1;
        end
        if (seen) begin
            error_count++;
            $display("ERR t=%0t test %0d: header sent where none was expected", $time, i);
        end
    endtask

    task automatic run_step(input int i);
        int    errs_before;
        int    k;
        hdr_t  got;
        ipv4_t got_ip;
        port_t got_port;
        logic  ok;
        errs_before = error_count;
        cur_step    = i;
        ok          = 1'b1;
        if (steps[i].is_send) begin
            send_request(steps[i].len, ok);
            if (ok && steps[i].len_b != '0) send_request(steps[i].len_b, ok);
        end else begin
            apply_rx(steps[i]);
        end
        if (ok && steps[i].n_hdr == 2'd0) expect_quiet(i);
        for (k = 0; k < steps[i].n_hdr && ok; k++) begin
            collect_header(got, got_ip, got_port, ok);
            if (ok) begin
                check_flags($sformatf("test %0d hdr %0d flags", i, k), got.flags,
                            exp_hdr[i][k].flags);
                check_seq($sformatf("test %0d hdr %0d seq", i, k), got.seq, exp_hdr[i][k].seq);
                check_seq($sformatf("test %0d hdr %0d ack", i, k), got.ack, exp_hdr[i][k].ack);
                check_len($sformatf("test %0d hdr %0d len", i, k), got.len, exp_hdr[i][k].len);
                check_ip($sformatf("test %0d hdr %0d dst ip", i, k), got_ip, CLI_IP);
                check_port($sformatf("test %0d hdr %0d dst port", i, k), got_port,
                           steps[i].src_port);
            end
        end
        check_bit($sformatf("test %0d connected", i), connected, steps[i].conn);
        tests_run++;
        if (error_count != errs_before) tests_failed++;
        $display("test %0d %s: %s", i, step_name[i],
                 (error_count == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int i;
        seed         = 32'habc1;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_step     = 0;
        timed_out    = 1'b0;
        tcp_rst      = 1'b1;
        loc_port     = LOC_PORT;
        listen       = 1'b0;
        rx_hdr_v     = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_seq       = '0;
        rx_ack       = '0;
        rx_flags     = '0;
        rx_len       = '0;
        send_v       = 1'b0;
        send_len     = '0;
        tx_ack       = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        tcp_rst = 1'b0;
        listen  = 1'b1;  // stays high, server listens again after the close
        next_cycle();
        for (i = 0; i < NROWS && !timed_out; i++) begin
            run_step(i);
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/tcp_server_top.sv
`default_nettype none

module tcp_server_top (
    input  wire logic            clk,
    input  wire logic            tcp_rst,
    input  wire tcp_pkg::port_t  loc_port,
    input  wire logic            listen,
    output logic                 connected,
    // incoming header, rx_hdr_v qualifies the rest
    input  wire logic            rx_hdr_v,
    input  wire tcp_pkg::ipv4_t  rx_src_ip,
    input  wire tcp_pkg::port_t  rx_src_port,
    input  wire tcp_pkg::port_t  rx_dst_port,
    input  wire tcp_pkg::seq_t   rx_seq,
    input  wire tcp_pkg::seq_t   rx_ack,
    input  wire tcp_pkg::flags_t rx_flags,
    input  wire tcp_pkg::len_t   rx_len,
    // application send request
    input  wire logic            send_v,
    input  wire tcp_pkg::len_t   send_len,
    output logic                 send_rdy,
    // outgoing header, four-phase req/ack
    output logic                 tx_req,
    input  wire logic            tx_ack,
    output tcp_pkg::ipv4_t       tx_dst_ip,
    output tcp_pkg::port_t       tx_dst_port,
    output tcp_pkg::seq_t        tx_seq,
    output tcp_pkg::seq_t        tx_ack_num,
    output tcp_pkg::flags_t      tx_flags,
    output tcp_pkg::len_t        tx_len
);

    rx_seg_if rx_seg ();
    seg_if    eng_seg ();   // engine to fifo
    seg_if    fifo_seg ();  // fifo to transmit port

    rx_seg_classifier u_classifier (
        .clk         (clk),
        .tcp_rst     (tcp_rst),
        .loc_port    (loc_port),
        .rx_hdr_v    (rx_hdr_v),
        .rx_src_ip   (rx_src_ip),
        .rx_src_port (rx_src_port),
        .rx_dst_port (rx_dst_port),
        .rx_seq      (rx_seq),
        .rx_ack      (rx_ack),
        .rx_flags    (rx_flags),
        .rx_len      (rx_len),
        .seg         (rx_seg.src)
    );

    tcp_conn_engine u_engine (
        .clk       (clk),
        .tcp_rst   (tcp_rst),
        .listen    (listen),
        .rx        (rx_seg.dst),
        .send_v    (send_v),
        .send_len  (send_len),
        .send_rdy  (send_rdy),
        .connected (connected),
        .tx        (eng_seg.src)
    );

    tx_hdr_fifo u_fifo (
        .clk     (clk),
        .tcp_rst (tcp_rst),
        .wr      (eng_seg.dst),
        .rd      (fifo_seg.src)
    );

    tx_req_ack_port u_tx_port (
        .clk         (clk),
        .tcp_rst     (tcp_rst),
        .hdr         (fifo_seg.dst),
        .tx_req      (tx_req),
        .tx_ack      (tx_ack),
        .tx_dst_ip   (tx_dst_ip),
        .tx_dst_port (tx_dst_port),
        .tx_seq      (tx_seq),
        .tx_ack_num  (tx_ack_num),
        .tx_flags    (tx_flags),
        .tx_len      (tx_len)
    );

endmodule

`default_nettype wire

// File: source/tx_req_ack_port.sv
`default_nettype none

module tx_req_ack_port (
    input  wire logic       clk,
    input  wire logic       tcp_rst,
    seg_if.dst              hdr,
    output logic            tx_req,
    input  wire logic       tx_ack,
    output tcp_pkg::ipv4_t  tx_dst_ip,
    output tcp_pkg::port_t  tx_dst_port,
    output tcp_pkg::seq_t   tx_seq,
    output tcp_pkg::seq_t   tx_ack_num,
    output tcp_pkg::flags_t tx_flags,
    output tcp_pkg::len_t   tx_len
);

    typedef enum logic [1:0] {
        p_idle,
        p_wait_ack_high,
        p_wait_ack_low
    } port_state_t;

    port_state_t state;

    // pop exactly once, on the cycle tx_ack is first seen high
    assign hdr.ready = (state == p_wait_ack_high) && tx_ack;

    always_ff @(posedge clk) begin
        if (tcp_rst) begin
            state  <= p_idle;
            tx_req <= 1'b0;
        end else begin
            case (state)
                p_idle: begin
                    if (hdr.valid && !tx_ack) begin // previous ack must be gone
                        tx_req <= 1'b1;
                        state  <= p_wait_ack_high;
                    end
                end
                p_wait_ack_high: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= p_wait_ack_low;
                    end
                end
                p_wait_ack_low: begin
                    if (!tx_ack) begin
                        state <= p_idle;
                    end
                end
                default: state <= p_idle;
            endcase
        end
    end

    // fields only change in idle, so they hold until tx_ack falls
    always_ff @(posedge clk) begin
        if (state == p_idle && hdr.valid && !tx_ack) begin
            tx_dst_ip   <= hdr.dst_ip;
            tx_dst_port <= hdr.dst_port;
            tx_seq      <= hdr.seq;
            tx_ack_num  <= hdr.ack;
            tx_flags    <= hdr.flags;
            tx_len      <= hdr.len;
        end
    end

endmodule

`default_nettype wire

// File: source/tx_hdr_fifo.sv
`default_nettype none

`include "tcp_macros.svh"

module tx_hdr_fifo (
    input  wire logic clk,
    input  wire logic tcp_rst,
    seg_if.dst        wr,
    seg_if.src        rd
);
    import tcp_pkg::*;

    localparam int DEPTH = `TX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    ipv4_t   mem_ip    [DEPTH];
    port_t   mem_port  [DEPTH];
    seq_t    mem_seq   [DEPTH];
    seq_t    mem_ack   [DEPTH];
    flags_t  mem_flags [DEPTH];
    len_t    mem_len   [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign wr.ready = (count != (AW+1)'(DEPTH));
    assign rd.valid = (count != '0);
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    // head is read straight from the store
    assign rd.dst_ip   = mem_ip[rd_ptr];
    assign rd.dst_port = mem_port[rd_ptr];
    assign rd.seq      = mem_seq[rd_ptr];
    assign rd.ack      = mem_ack[rd_ptr];
    assign rd.flags    = mem_flags[rd_ptr];
    assign rd.len      = mem_len[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_ip[wr_ptr]    <= wr.dst_ip;
            mem_port[wr_ptr]  <= wr.dst_port;
            mem_seq[wr_ptr]   <= wr.seq;
            mem_ack[wr_ptr]   <= wr.ack;
            mem_flags[wr_ptr] <= wr.flags;
            mem_len[wr_ptr]   <= wr.len;
        end
    end

    always_ff @(posedge clk) begin
        if (tcp_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/tcp_conn_engine.sv
`default_nettype none

`include "tcp_macros.svh"

module tcp_conn_engine (
    input  wire logic           clk,
    input  wire logic           tcp_rst,
    input  wire logic           listen,
    rx_seg_if.dst               rx,
    input  wire logic           send_v,
    input  wire tcp_pkg::len_t  send_len,
    output logic                send_rdy,
    output logic                connected,
    seg_if.src                  tx
);
    import tcp_pkg::*;

    conn_state_t state;
    ipv4_t       rem_ip;
    port_t       rem_port;
    seq_t        loc_seq;
    seq_t        loc_ack;
    logic        busy;
    logic        rx_peer;

    // no new rx or send while a header is pending
    assign busy     = tx.valid;
    assign rx_peer  = rx.v && !busy && (rx.src_port == rem_port);
    assign send_rdy = (state == st_established) && !busy;

    // every header goes to the peer latched on the SYN
    assign tx.dst_ip   = rem_ip;
    assign tx.dst_port = rem_port;

    always_ff @(posedge clk) begin
        if (tcp_rst) begin
            state     <= st_closed;
            connected <= 1'b0;
            tx.valid  <= 1'b0;
            rem_ip    <= '0;
            rem_port  <= '0;
            loc_seq   <= '0;
            loc_ack   <= '0;
        end else begin
            if (tx.valid && tx.ready) begin
                tx.valid <= 1'b0;
            end
            case (state)
                st_closed: begin
                    if (listen) begin
                        state <= st_listen;
                    end
                end
                st_listen: begin
                    if (!listen) begin
                        state <= st_closed;
                    end else if (rx.v && !busy && rx.kind == kind_syn) begin
                        rem_ip      <= rx.src_ip;
                        rem_port    <= rx.src_port;
                        loc_seq     <= `TCP_ISN;
                        loc_ack     <= rx.seq + 32'd1;
                        tx.seq      <= `TCP_ISN;
                        tx.ack      <= rx.seq + 32'd1;
                        tx.flags    <= `TCP_FLAG_SYNACK;
                        tx.len      <= '0;
                        tx.valid    <= 1'b1;
                        state       <= st_syn_rcvd;
                    end
                end
                st_syn_rcvd: begin
                    if (rx_peer && rx.kind == kind_ack && rx.ack == `TCP_ISN + 32'd1) begin
                        loc_seq   <= `TCP_ISN + 32'd1; // SYN took one number
                        connected <= 1'b1;
                        state     <= st_established;
                    end
                end
                st_established: begin
                    if (send_v && send_rdy) begin
                        loc_seq  <= loc_seq + seq_t'(send_len);
                        tx.seq   <= loc_seq;
                        tx.ack   <= loc_ack;
                        tx.flags <= `TCP_FLAG_PSHACK;
                        tx.len   <= send_len;
                        tx.valid <= 1'b1;
                    end else if (rx_peer && rx.kind == kind_fin) begin
                        loc_ack  <= loc_ack + 32'd1;
                        tx.seq   <= loc_seq;
                        tx.ack   <= loc_ack + 32'd1;
                        tx.flags <= `TCP_FLAG_ACK;
                        tx.len   <= '0;
                        tx.valid <= 1'b1;
                        state    <= st_ack_fin;
                    end else if (rx_peer && rx.kind == kind_data && rx.seq == loc_ack) begin
                        loc_ack  <= loc_ack + seq_t'(rx.len); // in order only
                        tx.seq   <= loc_seq;
                        tx.ack   <= loc_ack + seq_t'(rx.len);
                        tx.flags <= `TCP_FLAG_ACK;
                        tx.len   <= '0;
                        tx.valid <= 1'b1;
                    end
                end
                st_ack_fin: begin
                    if (!busy) begin
                        state <= st_send_fin;
                    end
                end
                st_send_fin: begin
                    if (!busy) begin
                        tx.seq   <= loc_seq;
                        tx.ack   <= loc_ack; // already past the peer FIN
                        tx.flags <= `TCP_FLAG_FINACK;
                        tx.len   <= '0;
                        tx.valid <= 1'b1;
                        state    <= st_last_ack;
                    end
                end
                st_last_ack: begin
                    if (rx_peer && rx.kind == kind_ack) begin
                        connected <= 1'b0;
                        state     <= st_closed;
                    end
                end
                default: state <= st_closed;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/rx_seg_classifier.sv
`default_nettype none

`include "tcp_macros.svh"

module rx_seg_classifier (
    input  wire logic            clk,
    input  wire logic            tcp_rst,
    input  wire tcp_pkg::port_t  loc_port,
    input  wire logic            rx_hdr_v,
    input  wire tcp_pkg::ipv4_t  rx_src_ip,
    input  wire tcp_pkg::port_t  rx_src_port,
    input  wire tcp_pkg::port_t  rx_dst_port,
    input  wire tcp_pkg::seq_t   rx_seq,
    input  wire tcp_pkg::seq_t   rx_ack,
    input  wire tcp_pkg::flags_t rx_flags,
    input  wire tcp_pkg::len_t   rx_len,
    rx_seg_if.src                seg
);
    import tcp_pkg::*;

    rx_kind_t kind_d;

    // fin wins over syn, syn over data, data over a bare ack
    always_comb begin
        if (|(rx_flags & `TCP_FLAG_FIN))      kind_d = kind_fin;
        else if (|(rx_flags & `TCP_FLAG_SYN)) kind_d = kind_syn;
        else if (rx_len != '0)                kind_d = kind_data;
        else if (|(rx_flags & `TCP_FLAG_ACK)) kind_d = kind_ack;
        else                                  kind_d = kind_other;
    end

    always_ff @(posedge clk) begin
        if (tcp_rst) begin
            seg.v <= 1'b0;
        end else begin
            seg.v <= rx_hdr_v && (rx_dst_port == loc_port); // foreign ports dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (rx_hdr_v) begin
            seg.kind     <= kind_d;
            seg.src_ip   <= rx_src_ip;
            seg.src_port <= rx_src_port;
            seg.seq      <= rx_seq;
            seg.ack      <= rx_ack;
            seg.len      <= rx_len;
        end
    end

endmodule

`default_nettype wire

// File: source/tcp_seg_if.sv
`default_nettype none

// classified rx segment, one cycle pulse on v, no back-pressure
interface rx_seg_if;
    import tcp_pkg::*;

    logic     v;
    rx_kind_t kind;
    ipv4_t    src_ip;
    port_t    src_port;
    seq_t     seq;
    seq_t     ack;
    len_t     len;

    modport src (output v, kind, src_ip, src_port, seq, ack, len);
    modport dst (input  v, kind, src_ip, src_port, seq, ack, len);
endinterface

// outgoing header, valid/ready
interface seg_if;
    import tcp_pkg::*;

    logic   valid;
    logic   ready;
    ipv4_t  dst_ip;
    port_t  dst_port;
    seq_t   seq;
    seq_t   ack;
    flags_t flags;
    len_t   len;

    modport src (output valid, dst_ip, dst_port, seq, ack, flags, len, input ready);
    modport dst (input  valid, dst_ip, dst_port, seq, ack, flags, len, output ready);
endinterface

`default_nettype wire

// File: source/tcp_pkg.sv
`default_nettype none

`include "tcp_macros.svh"

package tcp_pkg;

    typedef logic [`TCP_SEQ_W-1:0]   seq_t;
    typedef logic [`TCP_PORT_W-1:0]  port_t;
    typedef logic [`TCP_IP_W-1:0]    ipv4_t;
    typedef logic [`TCP_LEN_W-1:0]   len_t;
    typedef logic [`TCP_FLAGS_W-1:0] flags_t;

    // what the classifier made of an incoming header
    typedef enum logic [2:0] {
        kind_syn,
        kind_ack,
        kind_data,   // nonzero payload length
        kind_fin,
        kind_other
    } rx_kind_t;

    // connection engine states, passive open and passive close only
    typedef enum logic [2:0] {
        st_closed,
        st_listen,
        st_syn_rcvd,
        st_established,
        st_ack_fin,     // ack of the peer FIN waiting to leave
        st_send_fin,
        st_last_ack
    } conn_state_t;

endpackage

`default_nettype wire

// File: include/tcp_macros.svh
`ifndef TCP_MACROS_SVH
`define TCP_MACROS_SVH

// field widths
`define TCP_SEQ_W    32
`define TCP_PORT_W   16
`define TCP_IP_W     32
`define TCP_LEN_W    16
`define TCP_FLAGS_W  9

// server side initial sequence number, fixed
`define TCP_ISN      32'hfeadabba

// flag codes, bit 0 is FIN, bit 1 SYN, bit 3 PSH, bit 4 ACK
`define TCP_FLAG_FIN     9'h001
`define TCP_FLAG_SYN     9'h002
`define TCP_FLAG_ACK     9'h010
`define TCP_FLAG_FINACK  9'h011
`define TCP_FLAG_SYNACK  9'h012
`define TCP_FLAG_PSHACK  9'h018

// outgoing header queue
`define TX_FIFO_DEPTH    4

`endif
